//--- src.f
common/pcxt_pkg.sv
common/board_cfg_if.sv
rtl/status_decode.sv
rtl/ppi_port_glue.sv
reset/reset_sequencer.sv
reset/splash_timer.sv
audio/sample_strobe.sv
audio/sigma_delta_dac.sv
rtl/pcxt_board_top.sv
bench/pcxt_board_checker.sv
bench/board_monitor.sv
bench/tb_pcxt_board.sv

//--- Makefile
# Verilator build and run of the board glue testbench

TOP := tb_pcxt_board

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- bench/tb_pcxt_board.sv
/*
 * board glue testbench
 * stimulus table with three reset runs, random rows, watchdog and summary
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pcxt_board;

	localparam int RESET_HOLD       = 200;
	localparam int CPU_RESET_DELAY  = 42;
	localparam int SPLASH_SECONDS   = 5;
	localparam int TICKS_PER_SECOND = 1000;
	localparam int CLOCK_HZ         = 50000000;
	localparam int SAMPLE_RATE      = 44100;
	localparam int FIXED_ROWS       = 10;
	localparam int RAND_ROWS        = 30;
	localparam int NUM_ROWS         = FIXED_ROWS + RAND_ROWS + 1;

	typedef struct packed {
		logic        rst;
		logic [31:0] status;
		logic [7:0]  pb;
		logic        kclk;
		logic        kdat;
		logic [15:0] pcm_l;
		logic [15:0] pcm_r;
		logic [31:0] cyc;
	} stim_row_t;

	logic        CLK_50M;
	logic        reset_wire;
	logic [31:0] status;
	logic [7:0]  port_b_out;
	logic        ps2_kbd_clk_in;
	logic        ps2_kbd_data_in;
	logic [15:0] pcm_left;
	logic [15:0] pcm_right;
	logic [3:0]  port_c_low;
	logic        ps2_clk_sync;
	logic        ps2_data_sync;
	logic        sys_reset;
	logic        cpu_reset;
	logic        splash_active;
	logic        sample_en;
	logic        audio_l;
	logic        audio_r;
	logic        tandy_mode;
	logic        mda_mode;
	logic        adlib_hide;
	logic        ems_enabled;
	logic [7:0]  ems_segment;
	logic [2:0]  display_tint;
	int          errors;
	int          checks;
	int          dac_windows;

	stim_row_t   rows [NUM_ROWS];
	logic [31:0] rng = 32'd60633;
	int          budget = 0;
	int          bench_errors = 0;

	pcxt_board_top #(
		.RESET_HOLD       (RESET_HOLD),
		.CPU_RESET_DELAY  (CPU_RESET_DELAY),
		.SPLASH_SECONDS   (SPLASH_SECONDS),
		.TICKS_PER_SECOND (TICKS_PER_SECOND),
		.CLOCK_HZ         (CLOCK_HZ),
		.SAMPLE_RATE      (SAMPLE_RATE)
	) pcxt_board_top_inst (.*);

	board_monitor #(
		.RESET_HOLD       (RESET_HOLD),
		.CPU_RESET_DELAY  (CPU_RESET_DELAY),
		.SPLASH_SECONDS   (SPLASH_SECONDS),
		.TICKS_PER_SECOND (TICKS_PER_SECOND),
		.CLOCK_HZ         (CLOCK_HZ),
		.SAMPLE_RATE      (SAMPLE_RATE)
	) board_monitor_inst (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// 50 MHz board clock
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	initial begin
		wait (budget > 0);
		repeat (budget) @(posedge CLK_50M);
		$display("timeout: watchdog expired before the stimulus table finished");
		$display("tests failed");
		$finish;
	end

	initial begin
		reset_wire      = 1'b1;
		status          = '0;
		port_b_out      = '0;
		ps2_kbd_clk_in  = 1'b1;
		ps2_kbd_data_in = 1'b1;
		pcm_left        = '0;
		pcm_right       = '0;

		////////////////////////////////
		// run 1 skip set, run 2 full splash with audio, run 3 late skip
		rows[0] = {1'b1, 32'h0000_0088, 8'h00, 1'b1, 1'b1, 16'h0000, 16'h0000, 32'd300};
		rows[1] = {1'b0, 32'h0000_1890, 8'h08, 1'b0, 1'b1, 16'h0000, 16'h0000, 32'd5};
		rows[2] = {1'b0, 32'h0000_2480, 8'h08, 1'b1, 1'b0, 16'h0000, 16'h0000, 32'd5};
		rows[3] = {1'b0, 32'h0001_F090, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000, 32'd5};
		rows[4] = {1'b0, 32'h0000_0010, 8'h08, 1'b1, 1'b1, 16'h0000, 16'h0000, 32'd4};
		rows[5] = {1'b1, 32'h0000_0000, 8'h00, 1'b1, 1'b1, 16'h8000, 16'h4000, 32'd3300};
		rows[6] = {1'b0, 32'h0000_0010, 8'h08, 1'b1, 1'b1, 16'hFFFF, 16'h1234, 32'd3300};
		rows[7] = {1'b0, 32'h0000_0000, 8'h00, 1'b1, 1'b1, 16'h0000, 16'h7FFE, 32'd3300};
		rows[8] = {1'b1, 32'h0000_0000, 8'h00, 1'b1, 1'b1, 16'h1000, 16'h2000, 32'd1000};
		rows[9] = {1'b0, 32'h0000_0080, 8'h00, 1'b1, 1'b1, 16'h1000, 16'h2000, 32'd50};
		for (int i = FIXED_ROWS; i < NUM_ROWS; i++) begin
			rng = xorshift32(rng);
			rows[i].rst    = 1'b0;
			rows[i].status = rng;
			rng = xorshift32(rng);
			rows[i].pb     = rng[7:0];
			rows[i].kclk   = rng[8];
			rows[i].kdat   = rng[9];
			rows[i].pcm_l  = rng[31:16];
			rows[i].pcm_r  = rng[23:8];
			rows[i].cyc    = 32'd3;
		end
		// long constant row for the strobe rate window
		rows[NUM_ROWS-1].cyc = 32'd20500;

		budget = RESET_HOLD + SPLASH_SECONDS * TICKS_PER_SECOND + 1000;
		for (int i = 0; i < NUM_ROWS; i++)
			budget += int'(rows[i].cyc) + 12;

		for (int i = 0; i < NUM_ROWS; i++) begin
			@(posedge CLK_50M);
			#2;
			status          = rows[i].status;
			port_b_out      = rows[i].pb;
			ps2_kbd_clk_in  = rows[i].kclk;
			ps2_kbd_data_in = rows[i].kdat;
			pcm_left        = rows[i].pcm_l;
			pcm_right       = rows[i].pcm_r;
			if (rows[i].rst) begin
				reset_wire = 1'b1;
				repeat (10) @(posedge CLK_50M);
				#2;
				reset_wire = 1'b0;
			end
			repeat (int'(rows[i].cyc) - 1) @(posedge CLK_50M);
		end
		repeat (3) @(posedge CLK_50M);

		if (dac_windows == 0) begin
			bench_errors++;
			$display("no complete DAC density window was seen");
		end
		$display("checks %0d, monitor errors %0d, bench errors %0d, dac windows %0d",
			checks, errors, bench_errors, dac_windows);
		if (errors == 0 && bench_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/board_monitor.sv
/*
 * board glue monitor
 * reference model of the timing rules, compares every cycle, counts errors
 */
`timescale 1ns/1ps
`default_nettype none

module board_monitor #(
	parameter int RESET_HOLD       = 65535,
	parameter int CPU_RESET_DELAY  = 42,
	parameter int SPLASH_SECONDS   = 5,
	parameter int TICKS_PER_SECOND = 50000000,
	parameter int CLOCK_HZ         = 50000000,
	parameter int SAMPLE_RATE      = 44100
) (
	input  logic        CLK_50M,
	input  logic        reset_wire,
	input  logic [31:0] status,
	input  logic [7:0]  port_b_out,
	input  logic        ps2_kbd_clk_in,
	input  logic        ps2_kbd_data_in,
	input  logic [15:0] pcm_left,
	input  logic [15:0] pcm_right,
	input  logic [3:0]  port_c_low,
	input  logic        ps2_clk_sync,
	input  logic        ps2_data_sync,
	input  logic        sys_reset,
	input  logic        cpu_reset,
	input  logic        splash_active,
	input  logic        sample_en,
	input  logic        audio_l,
	input  logic        audio_r,
	input  logic        tandy_mode,
	input  logic        mda_mode,
	input  logic        adlib_hide,
	input  logic        ems_enabled,
	input  logic [7:0]  ems_segment,
	input  logic [2:0]  display_tint,
	output int          errors,
	output int          checks,
	output int          dac_windows
);
	import pcxt_pkg::*;

	localparam int SPLASH_CYC = SPLASH_SECONDS * TICKS_PER_SECOND;
	localparam int RATE_WIN   = 20000;
	localparam int DAC_WIN    = 2048;

	int err_cnt = 0;
	int chk_cnt = 0;
	int win_cnt = 0;
	// sample index since reset release
	int n;
	int both_low_n;
	int strobe_cnt;
	int dac_left;
	int ones_l;
	int ones_r;
	longint rate_diff;
	logic [31:0] status_q;
	logic        skip_seen;
	// {clk, data} one and two samples back
	logic [1:0]  ps2_h1;
	logic [1:0]  ps2_h2;
	logic [15:0] win_l;
	logic [15:0] win_r;
	logic        exp_sys;
	logic        exp_splash;
	logic        exp_cpu;
	logic        exp_mda;
	logic        live;
	logic [7:0]  sw;
	logic [1:0]  ps2_exp;

	assign errors      = err_cnt;
	assign checks      = chk_cnt;
	assign dac_windows = win_cnt;

	function automatic logic [7:0] frame_segment(input logic [1:0] code);
		if (code == 2'd0)
			return EMS_SEG_A000;
		else if (code == 2'd1)
			return EMS_SEG_C000;
		return EMS_SEG_D000;
	endfunction

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// ones over the window within 1 of W * (pcm / 2) / 65536
	task automatic check_density(input string what, input int ones, input logic [15:0] pcm);
		longint diff;
		diff = longint'(ones) * 65536 - longint'(DAC_WIN) * longint'(pcm >> 1);
		chk_cnt++;
		if (diff > 65536 || diff < -65536) begin
			err_cnt++;
			$display("[FAIL] %0t ns: %s has %0d ones for pcm %0h", $time, what, ones, pcm);
		end
	endtask

	always @(posedge CLK_50M) begin
		if (reset_wire) begin
			n          = 0;
			both_low_n = -1;
			skip_seen  = 1'b0;
			ps2_h1     = 2'b00;
			ps2_h2     = 2'b00;
			strobe_cnt = 0;
			dac_left   = 0;
		end else begin
			//////////////////////////////
			// reset and splash
			//////////////////////////////
			exp_sys    = (n <= RESET_HOLD);
			exp_splash = !skip_seen && (n <= RESET_HOLD + SPLASH_CYC);
			if (!exp_sys && !exp_splash && both_low_n < 0)
				both_low_n = n;
			exp_cpu = (both_low_n < 0) || (n <= both_low_n + CPU_RESET_DELAY);
			check_val("sys_reset", 32'(sys_reset), 32'(exp_sys));
			check_val("splash_active", 32'(splash_active), 32'(exp_splash));
			check_val("cpu_reset", 32'(cpu_reset), 32'(exp_cpu));

			// options lag the status word by one cycle
			live    = (n > 0);
			exp_mda = live && status_q[ST_MDA];
			check_val("tandy_mode", 32'(tandy_mode), 32'(live && status_q[ST_TANDY]));
			check_val("mda_mode", 32'(mda_mode), 32'(exp_mda));
			check_val("adlib_hide", 32'(adlib_hide), 32'(live && status_q[ST_ADLIB_HIDE]));
			check_val("ems_enabled", 32'(ems_enabled), 32'(live && !status_q[ST_EMS_OFF]));
			check_val("ems_segment", 32'(ems_segment),
				live ? 32'(frame_segment(status_q[13:12])) : 32'd0);
			check_val("display_tint", 32'(display_tint), live ? 32'(status_q[16:14]) : 32'd0);

			// port C and keyboard lines
			sw = exp_mda ? SW_MDA : SW_CGA;
			check_val("port_c_low", 32'(port_c_low),
				port_b_out[3] ? 32'(sw >> 4) : 32'(sw & 8'h0F));
			ps2_exp = (n >= 2) ? ps2_h2 : 2'b00;
			check_val("ps2_clk_sync", 32'(ps2_clk_sync), 32'(ps2_exp[1]));
			check_val("ps2_data_sync", 32'(ps2_data_sync), 32'(ps2_exp[0]));

			if (live && status_q[ST_SPLASH_SKIP])
				skip_seen = 1'b1;
			ps2_h2   = ps2_h1;
			ps2_h1   = {ps2_kbd_clk_in, ps2_kbd_data_in};
			status_q = status;

			//////////////////////////////
			// audio
			//////////////////////////////
			if (sample_en)
				strobe_cnt++;
			if ((n + 1) % RATE_WIN == 0) begin
				rate_diff = longint'(strobe_cnt) * CLOCK_HZ - longint'(RATE_WIN) * SAMPLE_RATE;
				chk_cnt++;
				if (rate_diff > CLOCK_HZ || rate_diff < -CLOCK_HZ) begin
					err_cnt++;
					$display("[FAIL] %0t ns: %0d strobes in %0d cycles", $time, strobe_cnt,
						RATE_WIN);
				end
				strobe_cnt = 0;
			end

			if (dac_left > 0) begin
				// window dropped if the input moves
				if (pcm_left != win_l || pcm_right != win_r) begin
					dac_left = 0;
				end else begin
					ones_l += int'(audio_l);
					ones_r += int'(audio_r);
					dac_left--;
					if (dac_left == 0) begin
						check_density("audio_l", ones_l, win_l);
						check_density("audio_r", ones_r, win_r);
						win_cnt++;
					end
				end
			end else if (sample_en) begin
				win_l    = pcm_left;
				win_r    = pcm_right;
				ones_l   = 0;
				ones_r   = 0;
				dac_left = DAC_WIN;
			end
			n++;
		end
	end

endmodule

`default_nettype wire

//--- bench/pcxt_board_checker.sv
/*
 * board glue protocol assertions
 * bound into the top level, watches reset ordering and the sample strobe
 */
`timescale 1ns/1ps
`default_nettype none

module pcxt_board_checker (
	input logic CLK_50M,
	input logic reset_wire,
	input logic sys_reset,
	input logic cpu_reset,
	input logic splash_active,
	input logic sample_en
);

	// CPU is never out of reset before the board
	cpu_under_sys: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		sys_reset |-> cpu_reset)
		else $error("cpu_reset low while sys_reset is high");

	// strobe is a single-cycle pulse
	strobe_single: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		sample_en |=> !sample_en)
		else $error("sample_en high on two cycles in a row");

	// splash only ends, it never comes back
	splash_no_rise: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		!splash_active |=> !splash_active)
		else $error("splash_active rose after reset ended");

endmodule

bind pcxt_board_top pcxt_board_checker pcxt_board_checker_inst (.*);

`default_nettype wire

//--- rtl/pcxt_board_top.sv
/*
 * PC/XT board glue top level
 * reset sequencing, splash timer, option decode, port C glue and audio DACs
 */
`timescale 1ns/1ps
`default_nettype none

module pcxt_board_top #(
	parameter int RESET_HOLD       = 65535,
	parameter int CPU_RESET_DELAY  = 42,
	parameter int SPLASH_SECONDS   = 5,
	parameter int TICKS_PER_SECOND = 50000000,
	parameter int CLOCK_HZ         = 50000000,
	parameter int SAMPLE_RATE      = 44100
) (
	input  logic                           CLK_50M,
	input  logic                           reset_wire,
	input  logic [pcxt_pkg::STATUS_W-1:0]  status,
	input  logic [7:0]                     port_b_out,
	input  logic                           ps2_kbd_clk_in,
	input  logic                           ps2_kbd_data_in,
	input  logic [pcxt_pkg::PCM_W-1:0]     pcm_left,
	input  logic [pcxt_pkg::PCM_W-1:0]     pcm_right,
	output logic [3:0]                     port_c_low,
	output logic                           ps2_clk_sync,
	output logic                           ps2_data_sync,
	output logic                           sys_reset,
	output logic                           cpu_reset,
	output logic                           splash_active,
	output logic                           sample_en,
	output logic                           audio_l,
	output logic                           audio_r,
	output logic                           tandy_mode,
	output logic                           mda_mode,
	output logic                           adlib_hide,
	output logic                           ems_enabled,
	output logic [pcxt_pkg::SEG_W-1:0]     ems_segment,
	output logic [pcxt_pkg::TINT_W-1:0]    display_tint
);
	import pcxt_pkg::*;

	board_cfg_if cfg_if ();

	// channel 0 left, channel 1 right
	logic [PCM_W-1:0] pcm_ch [2];
	logic [1:0]       audio_bits;

	//////////////////////////////
	// options and keyboard glue
	//////////////////////////////
	status_decode status_decode_inst (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.status     (status),
		.cfg        (cfg_if.source)
	);

	ppi_port_glue ppi_port_glue_inst (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.cfg           (cfg_if.sink),
		.port_b_out    (port_b_out),
		.port_c_low    (port_c_low),
		.ps2_clk_in    (ps2_kbd_clk_in),
		.ps2_data_in   (ps2_kbd_data_in),
		.ps2_clk_sync  (ps2_clk_sync),
		.ps2_data_sync (ps2_data_sync)
	);

	assign tandy_mode   = cfg_if.tandy_mode;
	assign mda_mode     = cfg_if.mda_mode;
	assign adlib_hide   = cfg_if.adlib_hide;
	assign ems_enabled  = cfg_if.ems_enabled;
	assign ems_segment  = cfg_if.ems_segment;
	assign display_tint = cfg_if.display_tint;

	//////////////////////////////
	// reset and splash
	//////////////////////////////
	reset_sequencer #(
		.RESET_HOLD      (RESET_HOLD),
		.CPU_RESET_DELAY (CPU_RESET_DELAY)
	) reset_sequencer_inst (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.splash_active (splash_active),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset)
	);

	splash_timer #(
		.SPLASH_SECONDS   (SPLASH_SECONDS),
		.TICKS_PER_SECOND (TICKS_PER_SECOND)
	) splash_timer_inst (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.sys_reset     (sys_reset),
		.cfg           (cfg_if.sink),
		.splash_active (splash_active)
	);

	//////////////////////////////
	// audio
	//////////////////////////////
	sample_strobe #(
		.CLOCK_HZ    (CLOCK_HZ),
		.SAMPLE_RATE (SAMPLE_RATE)
	) sample_strobe_inst (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.sample_en  (sample_en)
	);

	assign pcm_ch[0] = pcm_left;
	assign pcm_ch[1] = pcm_right;

	// both channels share the one strobe
	for (genvar ch = 0; ch < 2; ch++) begin : g_dac
		sigma_delta_dac sigma_delta_dac_inst (
			.CLK_50M    (CLK_50M),
			.reset_wire (reset_wire),
			.sample_en  (sample_en),
			.pcm        (pcm_ch[ch]),
			.bit_out    (audio_bits[ch])
		);
	end

	assign audio_l = audio_bits[0];
	assign audio_r = audio_bits[1];

endmodule

`default_nettype wire

//--- audio/sigma_delta_dac.sv
/*
 * one sigma-delta DAC channel
 * latches a PCM word on the strobe, halves it, first-order modulator to one bit
 */
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac (
	input  logic                       CLK_50M,
	input  logic                       reset_wire,
	input  logic                       sample_en,
	input  logic [pcxt_pkg::PCM_W-1:0] pcm,
	output logic                       bit_out
);
	import pcxt_pkg::*;

	logic [PCM_W-1:0] level_q;
	logic [PCM_W-1:0] level_next;
	logic [PCM_W-1:0] err_acc;
	// one extra bit holds the carry
	logic [PCM_W:0]   acc_sum;

	// new word is used on the strobe edge itself
	assign level_next = sample_en ? {1'b0, pcm[PCM_W-1:1]} : level_q;
	assign acc_sum    = {1'b0, err_acc} + {1'b0, level_next};

	//////////////////////////////
	// sample latch and modulator
	//////////////////////////////
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			level_q <= '0;
			err_acc <= '0;
			bit_out <= 1'b0;
		end else begin
			level_q <= level_next;
			// leftover error rolls into the next cycle
			err_acc <= acc_sum[PCM_W-1:0];
			// carry out is the density bit
			bit_out <= acc_sum[PCM_W];
		end
	end

endmodule

`default_nettype wire

//--- audio/sample_strobe.sv
/*
 * audio sample strobe
 * fractional accumulator, one-cycle pulse at SAMPLE_RATE on average
 */
`timescale 1ns/1ps
`default_nettype none

module sample_strobe #(
	parameter int CLOCK_HZ    = 50000000,
	parameter int SAMPLE_RATE = 44100
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	output logic sample_en
);

	// room for the sum just before the wrap
	localparam int ACC_W = $clog2(CLOCK_HZ + SAMPLE_RATE);

	logic [ACC_W-1:0] phase_acc;
	logic [ACC_W-1:0] phase_sum;

	assign phase_sum = phase_acc + ACC_W'(SAMPLE_RATE);

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			phase_acc <= '0;
			sample_en <= 1'b0;
		end else if (phase_sum >= ACC_W'(CLOCK_HZ)) begin
			// keep the remainder so the long-run rate stays exact
			phase_acc <= phase_sum - ACC_W'(CLOCK_HZ);
			sample_en <= 1'b1;
		end else begin
			phase_acc <= phase_sum;
			sample_en <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- reset/splash_timer.sv
/*
 * splash screen timer
 * keeps the splash up for a number of seconds after system reset, or until skip
 */
`timescale 1ns/1ps
`default_nettype none

module splash_timer #(
	parameter int SPLASH_SECONDS   = 5,
	parameter int TICKS_PER_SECOND = 50000000
) (
	input  logic      CLK_50M,
	input  logic      reset_wire,
	input  logic      sys_reset,
	board_cfg_if.sink cfg,
	output logic      splash_active
);

	localparam int TICK_W = $clog2(TICKS_PER_SECOND + 1);
	localparam int SEC_W  = $clog2(SPLASH_SECONDS + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic [SEC_W-1:0]  sec_cnt;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			if (cfg.splash_skip) begin
				// user skip wins right away
				splash_active <= 1'b0;
			end else if (!sys_reset) begin
				// time only runs once the board is out of reset
				if (tick_cnt == TICK_W'(TICKS_PER_SECOND - 1)) begin
					tick_cnt <= '0;
					if (sec_cnt == SEC_W'(SPLASH_SECONDS - 1))
						splash_active <= 1'b0;
					else
						sec_cnt <= sec_cnt + 1'b1;
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- reset/reset_sequencer.sv
/*
 * board reset sequencer
 * stretches the raw reset into a long system hold, then releases the CPU
 * a fixed delay after both system reset and splash screen are gone
 */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int RESET_HOLD      = 65535,
	parameter int CPU_RESET_DELAY = 42
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic splash_active,
	output logic sys_reset,
	output logic cpu_reset
);

	localparam int HOLD_W  = $clog2(RESET_HOLD + 1);
	localparam int DELAY_W = $clog2(CPU_RESET_DELAY + 1);

	logic [HOLD_W-1:0]  hold_cnt;
	logic [DELAY_W-1:0] delay_cnt;

	//////////////////////////////
	// system reset hold
	//////////////////////////////
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset <= 1'b1;
			hold_cnt  <= '0;
		end else if (sys_reset) begin
			// first clean edge counts as cycle zero
			if (hold_cnt == HOLD_W'(RESET_HOLD))
				sys_reset <= 1'b0;
			else
				hold_cnt <= hold_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// CPU reset release
	//////////////////////////////
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset <= 1'b1;
			delay_cnt <= '0;
		end else if (sys_reset || splash_active) begin
			// restart the delay while anything still holds the CPU
			cpu_reset <= 1'b1;
			delay_cnt <= '0;
		end else if (cpu_reset) begin
			if (delay_cnt == DELAY_W'(CPU_RESET_DELAY))
				cpu_reset <= 1'b0;
			else
				delay_cnt <= delay_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/ppi_port_glue.sv
/*
 * keyboard controller side glue
 * DIP switch nibble for PPI port C and PS/2 line synchronizers
 */
`timescale 1ns/1ps
`default_nettype none

module ppi_port_glue (
	input  logic       CLK_50M,
	input  logic       reset_wire,
	board_cfg_if.sink  cfg,
	input  logic [7:0] port_b_out,
	output logic [3:0] port_c_low,
	input  logic       ps2_clk_in,
	input  logic       ps2_data_in,
	output logic       ps2_clk_sync,
	output logic       ps2_data_sync
);
	import pcxt_pkg::*;

	logic [SW_W-1:0] sw;
	// bit 1 clock, bit 0 data
	logic [1:0]      ps2_meta;
	logic [1:0]      ps2_stable;

	// switch byte follows the video card choice
	assign sw = cfg.mda_mode ? SW_MDA : SW_CGA;
	// port B bit 3 picks which half the BIOS reads
	assign port_c_low = port_b_out[3] ? sw[7:4] : sw[3:0];

	// two flops per line
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			ps2_meta   <= 2'b00;
			ps2_stable <= 2'b00;
		end else begin
			ps2_meta   <= {ps2_clk_in, ps2_data_in};
			ps2_stable <= ps2_meta;
		end
	end

	assign ps2_clk_sync  = ps2_stable[1];
	assign ps2_data_sync = ps2_stable[0];

endmodule

`default_nettype wire

//--- rtl/status_decode.sv
/*
 * menu status word decoder
 * registers the option fields of the status word, one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

module status_decode (
	input  logic                          CLK_50M,
	input  logic                          reset_wire,
	input  logic [pcxt_pkg::STATUS_W-1:0] status,
	board_cfg_if.source                   cfg
);
	import pcxt_pkg::*;

	// field slices from the raw word
	logic [EMS_FRAME_W-1:0] ems_frame;
	logic [TINT_W-1:0]      tint_field;

	assign ems_frame  = status[ST_EMS_FRAME_LO +: EMS_FRAME_W];
	assign tint_field = status[ST_TINT_LO +: TINT_W];

	//////////////////////////////
	// option registers
	//////////////////////////////
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cfg.tandy_mode   <= 1'b0;
			cfg.mda_mode     <= 1'b0;
			cfg.splash_skip  <= 1'b0;
			cfg.adlib_hide   <= 1'b0;
			cfg.ems_enabled  <= 1'b0;
			cfg.ems_segment  <= '0;
			cfg.display_tint <= '0;
		end else begin
			cfg.tandy_mode   <= status[ST_TANDY];
			cfg.mda_mode     <= status[ST_MDA];
			cfg.splash_skip  <= status[ST_SPLASH_SKIP];
			cfg.adlib_hide   <= status[ST_ADLIB_HIDE];
			// menu bit is "disabled", so flip it
			cfg.ems_enabled  <= ~status[ST_EMS_OFF];
			cfg.ems_segment  <= ems_frame_seg(ems_frame);
			cfg.display_tint <= tint_field;
		end
	end

endmodule

`default_nettype wire

//--- common/board_cfg_if.sv
/*
 * decoded machine options
 * driven once by the status decoder, read by the board glue blocks
 */
`timescale 1ns/1ps
`default_nettype none

interface board_cfg_if;
	import pcxt_pkg::*;

	logic              tandy_mode;
	logic              mda_mode;
	logic              splash_skip;
	logic              adlib_hide;
	logic              ems_enabled;
	logic [SEG_W-1:0]  ems_segment;
	// monochrome tint select
	logic [TINT_W-1:0] display_tint;

	modport source (
		output tandy_mode, mda_mode, splash_skip, adlib_hide,
		output ems_enabled, ems_segment, display_tint
	);

	modport sink (
		input tandy_mode, mda_mode, splash_skip, adlib_hide,
		input ems_enabled, ems_segment, display_tint
	);

endinterface

`default_nettype wire

//--- common/pcxt_pkg.sv
/*
 * PC/XT board glue shared definitions
 * widths, menu status bit map, DIP switch bytes and EMS frame segments
 */
`default_nettype none

package pcxt_pkg;

	// word widths
	localparam int STATUS_W    = 32;
	localparam int PCM_W       = 16;
	localparam int SW_W        = 8;
	localparam int SEG_W       = 8;
	localparam int EMS_FRAME_W = 2;
	localparam int TINT_W      = 3;

	//////////////////////////////
	// menu status bit map
	//////////////////////////////
	localparam int ST_TANDY        = 3;
	localparam int ST_MDA          = 4;
	localparam int ST_SPLASH_SKIP  = 7;
	localparam int ST_ADLIB_HIDE   = 10;
	// active low, set means EMS off
	localparam int ST_EMS_OFF      = 11;
	// low bits of the multi-bit fields
	localparam int ST_EMS_FRAME_LO = 12;
	localparam int ST_TINT_LO      = 14;

	// DIP switch bytes, MDA or CGA 80 columns
	localparam logic [SW_W-1:0] SW_MDA = 8'h3D;
	localparam logic [SW_W-1:0] SW_CGA = 8'h2D;

	// EMS page frame, high byte of the segment
	localparam logic [SEG_W-1:0] EMS_SEG_A000 = 8'hA0;
	localparam logic [SEG_W-1:0] EMS_SEG_C000 = 8'hC0;
	localparam logic [SEG_W-1:0] EMS_SEG_D000 = 8'hD0;

	// frame code to segment, codes 2 and 3 both land on D000
	function automatic logic [SEG_W-1:0] ems_frame_seg(input logic [EMS_FRAME_W-1:0] code);
		case (code)
			2'd0:    return EMS_SEG_A000;
			2'd1:    return EMS_SEG_C000;
			default: return EMS_SEG_D000;
		endcase
	endfunction

endpackage

`default_nettype wire
